// ==== hdl/cpu16_pkg.sv ====
// Shared types and constants of the 16-bit CPU front end
// Instruction fields, opcodes and control register layout
// Fetch and execute item structs, FSM state enums

`default_nettype none

package cpu16_pkg;

	localparam int WORD_BITS     = 16;
	localparam int ADDR_BITS     = 16;
	localparam int REG_BITS      = 4;
	localparam int IRQ_BITS      = 4;
	localparam int CFG_ADDR_BITS = 4;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [REG_BITS-1:0]  reg_idx_t;

	// Field positions
	localparam int OPCODE_LSB  = 12;
	localparam int OPCODE_BITS = 4;
	localparam int DEST_LSB    = 8;
	localparam int SRCA_LSB    = 4;
	localparam int SRCB_LSB    = 0;
	localparam int IMM_HI_LSB  = 0;
	localparam int IMM_HI_BITS = 12;   // Upper immediate carried by IMM
	localparam int IMM_LO_LSB  = 0;
	localparam int IMM_LO_BITS = 4;

	localparam logic [OPCODE_BITS-1:0] OP_NOP    = 4'h0;
	localparam logic [OPCODE_BITS-1:0] OP_IMM    = 4'h1;
	localparam logic [OPCODE_BITS-1:0] OP_ALU_RR = 4'h2;
	localparam logic [OPCODE_BITS-1:0] OP_ALU_RI = 4'h3;
	localparam logic [OPCODE_BITS-1:0] OP_BRANCH = 4'h4;
	localparam logic [OPCODE_BITS-1:0] OP_INT    = 4'h5;

	localparam word_t NOP_INSTRUCTION = '0;
	localparam logic [WORD_BITS-IRQ_BITS-1:0] INT_BASE = {OP_INT, 8'h00};   // irq goes below
	localparam reg_idx_t R0 = '0;

	// Control register, bit 0 run, bit 1 interrupt enable
	localparam logic [CFG_ADDR_BITS-1:0] CFG_ADDR_CTRL = 4'h0;
	localparam int CTRL_RUN_BIT    = 0;
	localparam int CTRL_INT_EN_BIT = 1;

	localparam addr_t RESET_PC = '0;

	typedef struct packed {
		word_t instr;
		addr_t pc;
	} fetch_item_t;

	typedef struct packed {
		word_t instr;
		addr_t pc;
		word_t imm;
	} exec_item_t;

	localparam fetch_item_t BUBBLE_ITEM = '{instr: NOP_INSTRUCTION, pc: RESET_PC};

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_RELEASE} fetch_state_t;
	typedef enum logic {CFG_IDLE, CFG_ACK} cfg_state_t;

endpackage

`default_nettype wire

// ==== hdl/cpu16_fetch.sv ====
// Instruction fetch unit
// PC counter, four-phase instruction memory master,
// one-word holding buffer with back-pressure from the pipeline

`timescale 1ns/1ps
`default_nettype none

module cpu16_fetch (
	input  wire logic                  CLK,
	input  wire logic                  RSTb,
	input  wire logic                  run,
	input  wire logic                  load_pc,
	input  wire cpu16_pkg::addr_t      pc_in,
	input  wire logic                  fetch_take,
	output cpu16_pkg::fetch_item_t     fetch_item,
	output logic                       fetch_valid,
	output logic                       imem_req,
	output cpu16_pkg::addr_t           imem_addr,
	input  wire logic                  imem_ack,
	input  wire cpu16_pkg::word_t      imem_data
);

	cpu16_pkg::fetch_state_t state;
	cpu16_pkg::addr_t pc_r;
	cpu16_pkg::fetch_item_t buf_r;
	logic buf_valid;
	logic stale;    // Read in flight started before a redirect
	logic start;
	logic accept;

	// New read only with ack low and room in the buffer
	assign start = (state == cpu16_pkg::FETCH_IDLE) && run && !load_pc && !imem_ack &&
		(!buf_valid || fetch_take);
	assign accept = (state == cpu16_pkg::FETCH_REQ) && imem_ack && !stale && !load_pc;

	assign imem_req    = (state == cpu16_pkg::FETCH_REQ);
	assign fetch_item  = buf_r;
	assign fetch_valid = buf_valid;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= cpu16_pkg::FETCH_IDLE;
		end else begin
			case (state)
				cpu16_pkg::FETCH_IDLE:    if (start) state <= cpu16_pkg::FETCH_REQ;
				cpu16_pkg::FETCH_REQ:     if (imem_ack) state <= cpu16_pkg::FETCH_RELEASE;
				cpu16_pkg::FETCH_RELEASE: if (!imem_ack) state <= cpu16_pkg::FETCH_IDLE;
				default:                  state <= cpu16_pkg::FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc_r  <= cpu16_pkg::RESET_PC;
			stale <= 1'b0;
		end else begin
			if (load_pc)
				pc_r <= pc_in;
			else if (accept)
				pc_r <= pc_r + 1'b1;

			// Tag is dropped once the overtaken read gets its ack
			if ((state == cpu16_pkg::FETCH_REQ) && imem_ack)
				stale <= 1'b0;
			else if (load_pc && (state == cpu16_pkg::FETCH_REQ))
				stale <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			buf_valid <= 1'b0;
		else if (load_pc)
			buf_valid <= 1'b0;      // Wrong-path word
		else if (accept)
			buf_valid <= 1'b1;
		else if (fetch_take)
			buf_valid <= 1'b0;
	end

	// Address held stable for the whole handshake
	always_ff @(posedge CLK) begin
		if (start)
			imem_addr <= pc_r;
		if (accept)
			buf_r <= '{instr: imem_data, pc: imem_addr};
	end

endmodule

`default_nettype wire

// ==== hdl/cpu16_hazard.sv ====
// Hazard detector
// Destination and flag-write decode of stage 0,
// source and flag use of stage 1 against stages 2 and 3

`timescale 1ns/1ps
`default_nettype none

module cpu16_hazard (
	input  wire cpu16_pkg::word_t     stage0_instr,
	input  wire cpu16_pkg::word_t     stage1_instr,
	input  wire cpu16_pkg::reg_idx_t  hazard_reg2,
	input  wire cpu16_pkg::reg_idx_t  hazard_reg3,
	input  wire logic                 modifies_flags2,
	input  wire logic                 modifies_flags3,
	output cpu16_pkg::reg_idx_t       hazard_reg0,
	output logic                      modifies_flags0,
	output logic                      stall
);

	logic [cpu16_pkg::OPCODE_BITS-1:0] op0;
	logic [cpu16_pkg::OPCODE_BITS-1:0] op1;
	cpu16_pkg::reg_idx_t src_a;
	cpu16_pkg::reg_idx_t src_b;
	logic alu0;
	logic alu1;
	logic hit_a;
	logic hit_b;
	logic flag_hit;

	assign op0 = stage0_instr[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];
	assign op1 = stage1_instr[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];

	// Only ALU ops write a register and the flags
	assign alu0 = (op0 == cpu16_pkg::OP_ALU_RR) || (op0 == cpu16_pkg::OP_ALU_RI);
	assign hazard_reg0 = alu0 ? stage0_instr[cpu16_pkg::DEST_LSB +: cpu16_pkg::REG_BITS] :
		cpu16_pkg::R0;
	assign modifies_flags0 = alu0;

	assign alu1  = (op1 == cpu16_pkg::OP_ALU_RR) || (op1 == cpu16_pkg::OP_ALU_RI);
	assign src_a = stage1_instr[cpu16_pkg::SRCA_LSB +: cpu16_pkg::REG_BITS];
	assign src_b = stage1_instr[cpu16_pkg::SRCB_LSB +: cpu16_pkg::REG_BITS];

	// R0 never waits
	assign hit_a = alu1 && (src_a != cpu16_pkg::R0) &&
		((src_a == hazard_reg2) || (src_a == hazard_reg3));
	assign hit_b = (op1 == cpu16_pkg::OP_ALU_RR) && (src_b != cpu16_pkg::R0) &&
		((src_b == hazard_reg2) || (src_b == hazard_reg3));   // RI has an immediate here

	// Branch needs settled flags
	assign flag_hit = (op1 == cpu16_pkg::OP_BRANCH) && (modifies_flags2 || modifies_flags3);

	assign stall = hit_a || hit_b || flag_hit;

endmodule

`default_nettype wire

// ==== hdl/cpu16_ctrl_regs.sv ====
// Control register block
// Four-phase config slave holding run and interrupt enable

`timescale 1ns/1ps
`default_nettype none

module cpu16_ctrl_regs (
	input  wire logic                                 CLK,
	input  wire logic                                 RSTb,
	input  wire logic                                 cfg_req,
	input  wire logic [cpu16_pkg::CFG_ADDR_BITS-1:0]  cfg_addr,
	input  wire cpu16_pkg::word_t                     cfg_wdata,
	output logic                                      cfg_ack,
	input  wire logic                                 int_taken,
	output logic                                      run,
	output logic                                      int_enable
);

	cpu16_pkg::cfg_state_t state;
	logic wr_ctrl;

	// Write lands on the edge that raises ack
	assign wr_ctrl = (state == cpu16_pkg::CFG_IDLE) && cfg_req &&
		(cfg_addr == cpu16_pkg::CFG_ADDR_CTRL);

	assign cfg_ack = (state == cpu16_pkg::CFG_ACK);

	// Every request is acknowledged, unknown addresses included
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= cpu16_pkg::CFG_IDLE;
		end else begin
			case (state)
				cpu16_pkg::CFG_IDLE: if (cfg_req) state <= cpu16_pkg::CFG_ACK;
				cpu16_pkg::CFG_ACK:  if (!cfg_req) state <= cpu16_pkg::CFG_IDLE;
				default:             state <= cpu16_pkg::CFG_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			run        <= 1'b0;
			int_enable <= 1'b0;
		end else begin
			if (wr_ctrl)
				run <= cfg_wdata[cpu16_pkg::CTRL_RUN_BIT];

			// Injection wins over a host write in the same cycle
			if (int_taken)
				int_enable <= 1'b0;
			else if (wr_ctrl)
				int_enable <= cfg_wdata[cpu16_pkg::CTRL_INT_EN_BIT];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cpu16_pipeline.sv ====
// Five-stage instruction pipeline
// Instruction and PC of stages 0 to 2, hazard tags of stages 1 to 3
// Stall bubbles, flush on load_pc, INT injection, immediate register

`timescale 1ns/1ps
`default_nettype none

module cpu16_pipeline (
	input  wire logic                            CLK,
	input  wire logic                            RSTb,
	input  wire logic                            run,
	input  wire logic                            stall,
	input  wire logic                            load_pc,
	input  wire cpu16_pkg::fetch_item_t          fetch_item,
	input  wire logic                            fetch_valid,
	output logic                                 fetch_take,
	input  wire cpu16_pkg::reg_idx_t             hazard_reg0,
	input  wire logic                            modifies_flags0,
	output cpu16_pkg::word_t                     stage0_instr,
	output cpu16_pkg::word_t                     stage1_instr,
	output cpu16_pkg::reg_idx_t                  hazard_reg2,
	output cpu16_pkg::reg_idx_t                  hazard_reg3,
	output logic                                 modifies_flags2,
	output logic                                 modifies_flags3,
	input  wire logic                            int_enable,
	input  wire logic                            interrupt,
	input  wire logic [cpu16_pkg::IRQ_BITS-1:0]  irq,
	output logic                                 int_taken,
	output cpu16_pkg::exec_item_t                exec_item
);

	// Stages 3 and 4 belong to execute, only their tags are kept here
	cpu16_pkg::fetch_item_t stage_r [0:2];
	cpu16_pkg::fetch_item_t stage0_next;
	cpu16_pkg::reg_idx_t hazard_reg1;
	logic modifies_flags1;
	logic [cpu16_pkg::IMM_HI_BITS-1:0] imm_hi_r;
	cpu16_pkg::word_t imm2_r;     // Operand of the item in stage 2

	logic [cpu16_pkg::OPCODE_BITS-1:0] op0;
	logic [cpu16_pkg::OPCODE_BITS-1:0] op1;
	logic [cpu16_pkg::OPCODE_BITS-1:0] op2;
	logic [cpu16_pkg::OPCODE_BITS-1:0] op_fetch;
	logic shift;
	logic branch_near;
	logic inject;

	assign op0      = stage_r[0].instr[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];
	assign op1      = stage_r[1].instr[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];
	assign op2      = stage_r[2].instr[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];
	assign op_fetch = fetch_item.instr[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];

	assign shift = run && !stall && !load_pc;

	// A pending redirect could flush the INT or skip its return point
	assign branch_near = (op0 == cpu16_pkg::OP_BRANCH) || (op1 == cpu16_pkg::OP_BRANCH) ||
		(op2 == cpu16_pkg::OP_BRANCH) || (op_fetch == cpu16_pkg::OP_BRANCH);

	// IMM in stage 0 must stay next to its user
	assign inject = shift && int_enable && interrupt && fetch_valid && !branch_near &&
		(op0 != cpu16_pkg::OP_IMM);

	assign int_taken  = inject;
	assign fetch_take = shift && fetch_valid && !inject;   // Fetch word waits behind the INT

	always_comb begin
		if (inject)
			stage0_next = '{instr: {cpu16_pkg::INT_BASE, irq}, pc: fetch_item.pc};
		else if (fetch_valid)
			stage0_next = fetch_item;
		else
			stage0_next = cpu16_pkg::BUBBLE_ITEM;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage_r[0]      <= cpu16_pkg::BUBBLE_ITEM;
			stage_r[1]      <= cpu16_pkg::BUBBLE_ITEM;
			stage_r[2]      <= cpu16_pkg::BUBBLE_ITEM;
			hazard_reg1     <= cpu16_pkg::R0;
			hazard_reg2     <= cpu16_pkg::R0;
			hazard_reg3     <= cpu16_pkg::R0;
			modifies_flags1 <= 1'b0;
			modifies_flags2 <= 1'b0;
			modifies_flags3 <= 1'b0;
			imm_hi_r        <= '0;
			imm2_r          <= '0;
		end else if (load_pc) begin
			// Branch leaves stage 2, everything behind it is wrong path
			stage_r[0]      <= cpu16_pkg::BUBBLE_ITEM;
			stage_r[1]      <= cpu16_pkg::BUBBLE_ITEM;
			stage_r[2]      <= cpu16_pkg::BUBBLE_ITEM;
			hazard_reg1     <= cpu16_pkg::R0;
			hazard_reg2     <= cpu16_pkg::R0;
			hazard_reg3     <= hazard_reg2;
			modifies_flags1 <= 1'b0;
			modifies_flags2 <= 1'b0;
			modifies_flags3 <= modifies_flags2;
			imm_hi_r        <= '0;
			imm2_r          <= '0;
		end else if (run && stall) begin
			// Stages 0 and 1 hold, bubble into stage 2
			stage_r[2]      <= cpu16_pkg::BUBBLE_ITEM;
			hazard_reg2     <= cpu16_pkg::R0;
			hazard_reg3     <= hazard_reg2;
			modifies_flags2 <= 1'b0;
			modifies_flags3 <= modifies_flags2;
			imm2_r          <= '0;
		end else if (shift) begin
			stage_r[0]      <= stage0_next;
			stage_r[1]      <= stage_r[0];
			stage_r[2]      <= stage_r[1];
			hazard_reg1     <= hazard_reg0;
			hazard_reg2     <= hazard_reg1;
			hazard_reg3     <= hazard_reg2;
			modifies_flags1 <= modifies_flags0;
			modifies_flags2 <= modifies_flags1;
			modifies_flags3 <= modifies_flags2;
			imm2_r <= {imm_hi_r,
				stage_r[1].instr[cpu16_pkg::IMM_LO_LSB +: cpu16_pkg::IMM_LO_BITS]};

			// Upper part survives NOPs between IMM and its user
			if (op1 == cpu16_pkg::OP_IMM)
				imm_hi_r <= stage_r[1].instr[cpu16_pkg::IMM_HI_LSB +: cpu16_pkg::IMM_HI_BITS];
			else if (op1 != cpu16_pkg::OP_NOP)
				imm_hi_r <= '0;
		end
	end

	assign stage0_instr = stage_r[0].instr;
	assign stage1_instr = stage_r[1].instr;
	assign exec_item    = '{instr: stage_r[2].instr, pc: stage_r[2].pc, imm: imm2_r};

endmodule

`default_nettype wire

// ==== hdl/cpu16_core.sv ====
// CPU front end top level
// Fetch unit, hazard detector, control registers and pipeline

`timescale 1ns/1ps
`default_nettype none

module cpu16_core (
	input  wire logic                                 CLK,
	input  wire logic                                 RSTb,
	output logic                                      imem_req,
	output cpu16_pkg::addr_t                          imem_addr,
	input  wire logic                                 imem_ack,
	input  wire cpu16_pkg::word_t                     imem_data,
	input  wire logic                                 cfg_req,
	input  wire logic [cpu16_pkg::CFG_ADDR_BITS-1:0]  cfg_addr,
	input  wire cpu16_pkg::word_t                     cfg_wdata,
	output logic                                      cfg_ack,
	input  wire logic                                 load_pc,
	input  wire cpu16_pkg::addr_t                     pc_in,
	input  wire logic                                 interrupt,
	input  wire logic [cpu16_pkg::IRQ_BITS-1:0]       irq,
	output cpu16_pkg::exec_item_t                     exec_item
);

	cpu16_pkg::fetch_item_t fetch_item;
	logic fetch_valid;
	logic fetch_take;
	cpu16_pkg::word_t stage0_instr;
	cpu16_pkg::word_t stage1_instr;
	cpu16_pkg::reg_idx_t hazard_reg0;
	cpu16_pkg::reg_idx_t hazard_reg2;
	cpu16_pkg::reg_idx_t hazard_reg3;
	logic modifies_flags0;
	logic modifies_flags2;
	logic modifies_flags3;
	logic stall;
	logic run;
	logic int_enable;
	logic int_taken;

	cpu16_fetch u_fetch (
		.CLK, .RSTb, .run, .load_pc, .pc_in, .fetch_take,
		.fetch_item, .fetch_valid,
		.imem_req, .imem_addr, .imem_ack, .imem_data
	);

	cpu16_hazard u_hazard (
		.stage0_instr, .stage1_instr,
		.hazard_reg2, .hazard_reg3, .modifies_flags2, .modifies_flags3,
		.hazard_reg0, .modifies_flags0, .stall
	);

	cpu16_ctrl_regs u_ctrl_regs (
		.CLK, .RSTb, .cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack,
		.int_taken, .run, .int_enable
	);

	cpu16_pipeline u_pipeline (
		.CLK, .RSTb, .run, .stall, .load_pc,
		.fetch_item, .fetch_valid, .fetch_take,
		.hazard_reg0, .modifies_flags0,
		.stage0_instr, .stage1_instr,
		.hazard_reg2, .hazard_reg3, .modifies_flags2, .modifies_flags3,
		.int_enable, .interrupt, .irq, .int_taken,
		.exec_item
	);

endmodule

`default_nettype wire

// ==== testbench/cpu16_clkgen.sv ====
// Clock and reset generator for the CPU front end testbench
// 100 ns clock, reset held low for three cycles

`timescale 1ns/1ps
`default_nettype none

module cpu16_clkgen (
	output logic CLK,
	output logic RSTb
);

	localparam int HALF_PERIOD = 50;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);    // Released on a falling edge like every other input
		RSTb = 1'b1;
	end

endmodule

`default_nettype wire

// ==== testbench/cpu16_assert.sv ====
// Concurrent checks bound to cpu16_core
// Idle before run, both four-phase ports, INT handshake, register hazards at execute

`timescale 1ns/1ps
`default_nettype none

module cpu16_assert (
	input wire logic                   CLK,
	input wire logic                   RSTb,
	input wire logic                   imem_req,
	input wire logic                   imem_ack,
	input wire cpu16_pkg::addr_t       imem_addr,
	input wire logic                   cfg_req,
	input wire logic                   cfg_ack,
	input wire logic                   run,
	input wire logic                   int_enable,
	input wire logic                   int_taken,
	input wire cpu16_pkg::exec_item_t  exec_item
);

	int fail_count = 0;

	// True when rd reads a non-R0 register that wr writes
	function automatic logic raw_conflict(cpu16_pkg::word_t rd, cpu16_pkg::word_t wr);
		logic [cpu16_pkg::OPCODE_BITS-1:0] op_rd;
		logic [cpu16_pkg::OPCODE_BITS-1:0] op_wr;
		cpu16_pkg::reg_idx_t dest;
		logic hit_a;
		logic hit_b;
		op_rd = rd[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];
		op_wr = wr[cpu16_pkg::OPCODE_LSB +: cpu16_pkg::OPCODE_BITS];
		dest  = wr[cpu16_pkg::DEST_LSB +: cpu16_pkg::REG_BITS];
		hit_a = ((op_rd == cpu16_pkg::OP_ALU_RR) || (op_rd == cpu16_pkg::OP_ALU_RI)) &&
			(rd[cpu16_pkg::SRCA_LSB +: cpu16_pkg::REG_BITS] == dest);
		hit_b = (op_rd == cpu16_pkg::OP_ALU_RR) &&
			(rd[cpu16_pkg::SRCB_LSB +: cpu16_pkg::REG_BITS] == dest);   // RI has no srcB
		return ((op_wr == cpu16_pkg::OP_ALU_RR) || (op_wr == cpu16_pkg::OP_ALU_RI)) &&
			(dest != cpu16_pkg::R0) && (hit_a || hit_b);
	endfunction

	// Nothing moves before the host sets run
	a_idle_until_run: assert property (@(posedge CLK) disable iff (!RSTb)
		!run |-> !imem_req && !cfg_ack && (exec_item.instr == cpu16_pkg::NOP_INSTRUCTION))
		else begin
			$error("Activity while run is low");
			fail_count++;
		end

	a_imem_req_held: assert property (@(posedge CLK) disable iff (!RSTb)
		imem_req && !imem_ack |=> imem_req && $stable(imem_addr))
		else begin
			$error("imem_req dropped or address moved before ack");
			fail_count++;
		end

	a_imem_req_after_low_ack: assert property (@(posedge CLK) disable iff (!RSTb)
		$rose(imem_req) |-> !$past(imem_ack))
		else begin
			$error("New imem request while ack was still high");
			fail_count++;
		end

	a_cfg_ack_rises: assert property (@(posedge CLK) disable iff (!RSTb)
		cfg_req && !cfg_ack |=> cfg_ack)
		else begin
			$error("cfg request not acknowledged");
			fail_count++;
		end

	a_cfg_ack_falls: assert property (@(posedge CLK) disable iff (!RSTb)
		cfg_ack && !cfg_req |=> !cfg_ack)
		else begin
			$error("cfg_ack stuck after req dropped");
			fail_count++;
		end

	a_int_clears_enable: assert property (@(posedge CLK) disable iff (!RSTb)
		int_taken |=> !int_enable)
		else begin
			$error("int_enable still set after injection");
			fail_count++;
		end

	// Execute never sees a result that is one or two cycles old
	a_no_raw_hazard: assert property (@(posedge CLK) disable iff (!RSTb)
		run |-> !raw_conflict(exec_item.instr, $past(exec_item.instr)) &&
			!raw_conflict(exec_item.instr, $past(exec_item.instr, 2)))
		else begin
			$error("ALU at execute reads a register written too recently");
			fail_count++;
		end

endmodule

bind cpu16_core cpu16_assert u_assert (.*);

`default_nettype wire

// ==== testbench/cpu16_tb.sv ====
// Testbench of the CPU front end
// Instruction memory model with random ack delay, host writes, branch-taking execute model
// Scoreboard of the execute stream, cycle limit

`timescale 1ns/1ps
`default_nettype none

module cpu16_tb;

	localparam int PROG_WORDS    = 40;
	localparam int BRANCH_PC     = 20;
	localparam int BRANCH_TARGET = 24;
	localparam int WINDOW_PC     = 25;   // Interrupts get enabled after this item executes
	localparam logic [cpu16_pkg::IRQ_BITS-1:0] IRQ_VALUE = 4'hA;
	localparam int MAX_CYCLES    = PROG_WORDS * 50;   // Far above ~8 cycles per word

	logic CLK;
	logic RSTb;
	logic imem_req;
	cpu16_pkg::addr_t imem_addr;
	logic imem_ack;
	cpu16_pkg::word_t imem_data;
	logic cfg_req;
	logic [cpu16_pkg::CFG_ADDR_BITS-1:0] cfg_addr;
	cpu16_pkg::word_t cfg_wdata;
	logic cfg_ack;
	logic load_pc;
	cpu16_pkg::addr_t pc_in;
	logic interrupt;
	logic [cpu16_pkg::IRQ_BITS-1:0] irq;
	cpu16_pkg::exec_item_t exec_item;

	cpu16_pkg::word_t prog_mem [0:PROG_WORDS-1];
	cpu16_pkg::addr_t exp_q [$];         // Program addresses still to reach execute
	integer seed = 35;
	int mem_delay;
	logic mem_busy;
	int cycles;
	int int_count;
	logic int_armed;
	logic int_pending;
	logic int_window;
	cpu16_pkg::addr_t int_pc;
	logic [cpu16_pkg::IMM_HI_BITS-1:0] prev_upper;

	cpu16_clkgen u_clkgen (.CLK, .RSTb);

	cpu16_core UUT (
		.CLK, .RSTb,
		.imem_req, .imem_addr, .imem_ack, .imem_data,
		.cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack,
		.load_pc, .pc_in, .interrupt, .irq,
		.exec_item
	);

	function automatic logic [cpu16_pkg::OPCODE_BITS-1:0] opcode_of(cpu16_pkg::word_t w);
		return w[15:12];
	endfunction

	// Each ALU word reads the destination of the word before it
	function automatic cpu16_pkg::word_t alu_word(logic [3:0] op, int i);
		logic [3:0] d;
		logic [3:0] a;
		logic [3:0] b;
		d = 4'(i % 15 + 1);
		a = 4'((i + 14) % 15 + 1);
		b = (op == cpu16_pkg::OP_ALU_RI) ? 4'(i) : 4'((i + 13) % 15 + 1);
		return {op, d, a, b};
	endfunction

	task automatic build_program();
		for (int i = 0; i < PROG_WORDS; i++) begin
			if (i == BRANCH_PC)
				prog_mem[i] = {cpu16_pkg::OP_BRANCH, 12'(i)};
			else if ((i < BRANCH_PC) && (i % 5 == 0))
				prog_mem[i] = {cpu16_pkg::OP_IMM, 12'(i * 173 + 'h2c1)};
			else if ((i < BRANCH_PC) && (i % 5 == 1))
				prog_mem[i] = cpu16_pkg::NOP_INSTRUCTION;   // Gap between IMM and its user
			else
				prog_mem[i] = alu_word((i % 2 == 1) ? cpu16_pkg::OP_ALU_RI :
					cpu16_pkg::OP_ALU_RR, i);
		end
		// Words after the branch up to its target are never executed
		for (int i = 0; i < PROG_WORDS; i++)
			if (((i <= BRANCH_PC) || (i >= BRANCH_TARGET)) &&
					(prog_mem[i] != cpu16_pkg::NOP_INSTRUCTION))
				exp_q.push_back(cpu16_pkg::addr_t'(i));
	endtask

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		stop_with_failure($sformatf("ERR %0t: %s", $time, msg));
	endtask

	task automatic host_write(input logic [cpu16_pkg::CFG_ADDR_BITS-1:0] addr,
			input cpu16_pkg::word_t data);
		cfg_addr  = addr;
		cfg_wdata = data;
		cfg_req   = 1'b1;
		@(negedge CLK);
		while (!cfg_ack)
			@(negedge CLK);
		cfg_req = 1'b0;
		@(negedge CLK);
		while (cfg_ack)
			@(negedge CLK);
	endtask

	task automatic check_exec(input cpu16_pkg::exec_item_t item);
		cpu16_pkg::addr_t want_pc;
		cpu16_pkg::word_t want_imm;
		if (opcode_of(item.instr) == cpu16_pkg::OP_INT) begin
			if (!int_armed)
				report_mismatch("INT at execute while interrupts are disabled");
			if (int_count != 0)
				report_mismatch("second INT at execute");
			if (item.instr[3:0] != IRQ_VALUE)
				report_mismatch($sformatf("INT irq %h, expected %h", item.instr[3:0], IRQ_VALUE));
			int_count++;
			int_pending = 1'b1;
			int_pc      = item.pc;
			prev_upper  = '0;
		end else begin
			if ((item.pc > BRANCH_PC) && (item.pc < BRANCH_TARGET))
				report_mismatch($sformatf("wrong-path word at pc %h reached execute", item.pc));
			if (exp_q.size() == 0)
				report_mismatch($sformatf("unexpected item at pc %h", item.pc));
			want_pc = exp_q.pop_front();
			if (int_pending && (item.pc != int_pc))
				report_mismatch($sformatf("INT pc %h, next item pc %h", int_pc, item.pc));
			int_pending = 1'b0;
			if (item.pc != want_pc)
				report_mismatch($sformatf("pc %h, expected %h", item.pc, want_pc));
			if (item.instr != prog_mem[want_pc])
				report_mismatch($sformatf("instr %h at pc %h, expected %h",
					item.instr, item.pc, prog_mem[want_pc]));
			want_imm = {prev_upper, item.instr[3:0]};
			if (item.imm != want_imm)
				report_mismatch($sformatf("imm %h at pc %h, expected %h",
					item.imm, item.pc, want_imm));
			prev_upper = (opcode_of(item.instr) == cpu16_pkg::OP_IMM) ? item.instr[11:0] : '0;
			if (want_pc == WINDOW_PC)
				int_window = 1'b1;
		end
	endtask

	// Instruction memory model with an ack after 0 to 3 falling edges
	always @(negedge CLK) begin
		if (!RSTb) begin
			mem_busy = 1'b0;
		end else if (imem_ack) begin
			if (!imem_req)
				imem_ack = 1'b0;
		end else if (imem_req) begin
			if (!mem_busy) begin
				mem_busy  = 1'b1;
				mem_delay = $unsigned($random(seed)) % 4;
			end
			if (mem_delay == 0) begin
				imem_ack  = 1'b1;
				imem_data = (imem_addr < PROG_WORDS) ? prog_mem[imem_addr] :
					cpu16_pkg::NOP_INSTRUCTION;   // Unmapped space reads as NOP
				mem_busy  = 1'b0;
			end else begin
				mem_delay--;
			end
		end
	end

	// Execute takes every branch to a fixed target
	always @(negedge CLK) begin
		load_pc = RSTb && (opcode_of(exec_item.instr) == cpu16_pkg::OP_BRANCH);
		pc_in   = cpu16_pkg::addr_t'(BRANCH_TARGET);
	end

	always @(negedge CLK) begin
		if (RSTb) begin
			cycles++;
			if (cycles > MAX_CYCLES)
				stop_with_failure($sformatf("Timeout: run not done after %0d cycles", MAX_CYCLES));
			if (UUT.u_assert.fail_count != 0)
				stop_with_failure("A protocol or hazard assertion failed");
			if (exec_item.instr != cpu16_pkg::NOP_INSTRUCTION)
				check_exec(exec_item);
		end
	end

	initial begin
		cfg_req     = 1'b0;
		cfg_addr    = '0;
		cfg_wdata   = '0;
		imem_ack    = 1'b0;
		imem_data   = '0;
		load_pc     = 1'b0;
		pc_in       = '0;
		interrupt   = 1'b0;
		irq         = '0;
		cycles      = 0;
		int_count   = 0;
		int_armed   = 1'b0;
		int_pending = 1'b0;
		int_window  = 1'b0;
		int_pc      = '0;
		prev_upper  = '0;
		build_program();

		@(posedge RSTb);
		repeat (5) @(negedge CLK);   // Idle with run low

		// Interrupt pending from the start and masked until enabled
		interrupt = 1'b1;
		irq       = IRQ_VALUE;
		host_write(cpu16_pkg::CFG_ADDR_CTRL, 16'h0001);

		while (!int_window)
			@(posedge CLK);
		@(negedge CLK);
		int_armed = 1'b1;
		host_write(cpu16_pkg::CFG_ADDR_CTRL, 16'h0003);

		while (exp_q.size() != 0)
			@(posedge CLK);
		repeat (8) @(negedge CLK);   // Catch stray items after the program
		@(posedge CLK);

		if ((int_count == 1) && !int_pending) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			stop_with_failure($sformatf("Expected one INT followed by its return item, saw %0d",
				int_count));
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/cpu16_pkg.sv
hdl/cpu16_fetch.sv
hdl/cpu16_hazard.sv
hdl/cpu16_ctrl_regs.sv
hdl/cpu16_pipeline.sv
hdl/cpu16_core.sv
testbench/cpu16_clkgen.sv
testbench/cpu16_assert.sv
testbench/cpu16_tb.sv
